// File: hdl/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int xlen  = 32;
    localparam int nregs = 32;

    typedef logic [4:0]      reg_idx_t;
    typedef logic [xlen-1:0] word_t;

    // codes 9 to 14 are unassigned and decode as op_nop.
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_sll  = 4'd5,
        op_srl  = 4'd6,
        op_sltu = 4'd7,
        op_addi = 4'd8,
        op_nop  = 4'd15
    } alu_op_t;

    // bit 0 is spare.
    typedef struct packed {
        logic [3:0]  op;
        reg_idx_t    rd;
        reg_idx_t    rj;
        reg_idx_t    rk;
        logic [11:0] imm12;
        logic        spare;
    } instr_t;

    typedef struct packed {
        alu_op_t  op;
        reg_idx_t rd;
        reg_idx_t rj;
        reg_idx_t rk;
        word_t    imm;
        logic     writes;
    } dec_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t addr;
        word_t    data;
    } wb_t;

endpackage

`default_nettype wire

// File: hdl/issue_if.sv
`timescale 1ns/1ps
`default_nettype none

interface issue_if import core_pkg::*; ();

    logic valid;
    logic ready;
    dec_t slot0;
    dec_t slot1;
    logic has1;

    modport intake (
        output valid,
        output slot0,
        output slot1,
        output has1,
        input  ready
    );

    modport exec (
        input  valid,
        input  slot0,
        input  slot1,
        input  has1,
        output ready
    );

endinterface

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import core_pkg::*; (
    input  wire alu_op_t op,
    input  wire word_t   a,
    input  wire word_t   b,
    input  wire word_t   imm,
    output word_t        y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            op_add: begin
                y = a + b;
            end
            op_sub: begin
                y = a - b;
            end
            op_and: begin
                y = a & b;
            end
            op_or: begin
                y = a | b;
            end
            op_xor: begin
                y = a ^ b;
            end
            op_sll: begin
                y = a << shamt;
            end
            op_srl: begin
                y = a >> shamt;
            end
            op_sltu: begin
                y = (a < b) ? word_t'(1) : '0;
            end
            op_addi: begin
                y = a + imm;
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file import core_pkg::*; (
    input  wire           clk,
    input  wire           rstn,
    input  wire           we0,
    input  wire           we1,
    input  wire reg_idx_t wa0,
    input  wire reg_idx_t wa1,
    input  wire word_t    wd0,
    input  wire word_t    wd1,
    input  wire reg_idx_t ra0j,
    input  wire reg_idx_t ra0k,
    input  wire reg_idx_t ra1j,
    input  wire reg_idx_t ra1k,
    output word_t         rd0j,
    output word_t         rd0k,
    output word_t         rd1j,
    output word_t         rd1k,
    input  wire reg_idx_t dbg_num,
    output word_t         dbg_data
);

    word_t regs [nregs];

    // r0 reads zero, then port 1 bypass, then port 0 bypass, then storage.
    function automatic word_t read_port(
        reg_idx_t a,
        logic     w0,
        reg_idx_t a0,
        word_t    d0,
        logic     w1,
        reg_idx_t a1,
        word_t    d1,
        word_t    stored
    );
        word_t v;
        if (a == '0) begin
            v = '0;
        end else if (w1 && a1 == a) begin
            v = d1;
        end else if (w0 && a0 == a) begin
            v = d0;
        end else begin
            v = stored;
        end
        return v;
    endfunction

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < nregs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we0 && wa0 != '0) begin
                regs[wa0] <= wd0;
            end
            // port 1 is later in program order and wins a same-address write.
            if (we1 && wa1 != '0) begin
                regs[wa1] <= wd1;
            end
        end
    end

    always_comb begin
        rd0j = read_port(ra0j, we0, wa0, wd0, we1, wa1, wd1, regs[ra0j]);
        rd0k = read_port(ra0k, we0, wa0, wd0, we1, wa1, wd1, regs[ra0k]);
        rd1j = read_port(ra1j, we0, wa0, wd0, we1, wa1, wd1, regs[ra1j]);
        rd1k = read_port(ra1k, we0, wa0, wd0, we1, wa1, wd1, regs[ra1k]);
    end

    // debug view of storage only.
    assign dbg_data = regs[dbg_num];

endmodule

`default_nettype wire

// File: hdl/instr_intake.sv
`timescale 1ns/1ps
`default_nettype none

module instr_intake import core_pkg::*; (
    input  wire         clk,
    input  wire         rstn,
    input  wire         in_req,
    output logic        in_ack,
    input  wire instr_t in_instr0,
    input  wire instr_t in_instr1,
    input  wire         in_has1,
    issue_if.intake     issue
);

    instr_t instr0_q;
    instr_t instr1_q;
    logic   has1_q;
    logic   valid_q;
    logic   accept;

    function automatic dec_t decode(instr_t w);
        dec_t d;
        if (w.op <= op_addi) begin
            d.op = alu_op_t'(w.op);
        end else begin
            d.op = op_nop;
        end
        d.rd     = w.rd;
        d.rj     = w.rj;
        d.rk     = w.rk;
        d.imm    = {{(xlen-12){w.imm12[11]}}, w.imm12};
        d.writes = (d.op != op_nop) && (w.rd != '0);
        return d;
    endfunction

    // a new pair is only taken once the previous one left and the last ack dropped.
    assign accept = in_req && !in_ack && !valid_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            in_ack  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            if (accept) begin
                in_ack <= 1'b1;
            end else if (in_ack && !in_req) begin
                in_ack <= 1'b0;
            end
            if (accept) begin
                valid_q <= 1'b1;
            end else if (valid_q && issue.ready) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            instr0_q <= in_instr0;
            instr1_q <= in_instr1;
            has1_q   <= in_has1;
        end
    end

    assign issue.valid = valid_q;
    assign issue.slot0 = decode(instr0_q);
    assign issue.slot1 = decode(instr1_q);
    assign issue.has1  = has1_q;

endmodule

`default_nettype wire

// File: hdl/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage import core_pkg::*; (
    input  wire        clk,
    input  wire        rstn,
    issue_if.exec      issue,
    output reg_idx_t   ra0j,
    output reg_idx_t   ra0k,
    output reg_idx_t   ra1j,
    output reg_idx_t   ra1k,
    input  wire word_t rd0j,
    input  wire word_t rd0k,
    input  wire word_t rd1j,
    input  wire word_t rd1k,
    output wb_t        wb0,
    output wb_t        wb1,
    output logic       handoff,
    input  wire        out_empty
);

    logic     full_q;
    logic     pend1_q;
    logic     v0_q;
    logic     v1_q;
    reg_idx_t a0_q;
    reg_idx_t a1_q;
    word_t    d0_q;
    word_t    d1_q;
    logic     rd_hit;
    logic     split;
    logic     can_load;
    logic     go0;
    logic     go1;
    word_t    y0;
    word_t    y1;

    // slot 1 reads slot 0's destination, or both write the same register.
    assign rd_hit = issue.slot1.op != op_nop &&
                    (issue.slot1.rj == issue.slot0.rd ||
                     (issue.slot1.op != op_addi && issue.slot1.rk == issue.slot0.rd));
    assign split  = issue.has1 && issue.slot0.writes &&
                    (rd_hit || (issue.slot1.writes && issue.slot1.rd == issue.slot0.rd));

    assign handoff  = full_q && out_empty;
    assign can_load = issue.valid && (!full_q || handoff);
    assign go0      = can_load && !pend1_q;
    assign go1      = can_load && issue.has1 && (pend1_q || !split);

    // the pair leaves the intake together with its last part.
    assign issue.ready = can_load && (pend1_q || !split);

    assign ra0j = issue.slot0.rj;
    assign ra0k = issue.slot0.rk;
    assign ra1j = issue.slot1.rj;
    assign ra1k = issue.slot1.rk;

    alu alu0 (.op(issue.slot0.op), .a(rd0j), .b(rd0k), .imm(issue.slot0.imm), .y(y0));
    alu alu1 (.op(issue.slot1.op), .a(rd1j), .b(rd1k), .imm(issue.slot1.imm), .y(y1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            full_q  <= 1'b0;
            pend1_q <= 1'b0;
            v0_q    <= 1'b0;
            v1_q    <= 1'b0;
        end else if (can_load) begin
            full_q  <= 1'b1;
            pend1_q <= split && !pend1_q;
            v0_q    <= go0 && issue.slot0.writes;
            v1_q    <= go1 && issue.slot1.writes;
        end else if (handoff) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (can_load) begin
            a0_q <= issue.slot0.rd;
            d0_q <= y0;
            a1_q <= issue.slot1.rd;
            d1_q <= y1;
        end
    end

    // records are only valid on the handoff cycle, which is also the write cycle.
    assign wb0 = '{valid: v0_q && handoff, addr: a0_q, data: d0_q};
    assign wb1 = '{valid: v1_q && handoff, addr: a1_q, data: d1_q};

endmodule

`default_nettype wire

// File: hdl/result_port.sv
`timescale 1ns/1ps
`default_nettype none

module result_port import core_pkg::*; (
    input  wire      clk,
    input  wire      rstn,
    input  wire wb_t wb0,
    input  wire wb_t wb1,
    input  wire      handoff,
    output logic     empty,
    output logic     res_req,
    input  wire      res_ack,
    output reg_idx_t res_addr,
    output word_t    res_data
);

    logic     pend0_q;
    logic     pend1_q;
    reg_idx_t addr0_q;
    reg_idx_t addr1_q;
    word_t    data0_q;
    word_t    data1_q;
    logic     capture;

    assign empty   = !pend0_q && !pend1_q && !res_req && !res_ack;
    assign capture = handoff && empty;

    // slot 0 goes first while it is still pending.
    assign res_addr = pend0_q ? addr0_q : addr1_q;
    assign res_data = pend0_q ? data0_q : data1_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pend0_q <= 1'b0;
            pend1_q <= 1'b0;
            res_req <= 1'b0;
        end else if (capture) begin
            pend0_q <= wb0.valid;
            pend1_q <= wb1.valid;
        end else if (res_req && res_ack) begin
            res_req <= 1'b0;
            if (pend0_q) begin
                pend0_q <= 1'b0;
            end else begin
                pend1_q <= 1'b0;
            end
        end else if (!res_req && !res_ack && (pend0_q || pend1_q)) begin
            res_req <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            addr0_q <= wb0.addr;
            data0_q <= wb0.data;
            addr1_q <= wb1.addr;
            data1_q <= wb1.data;
        end
    end

endmodule

`default_nettype wire

// File: hdl/dual_issue_core.sv
`timescale 1ns/1ps
`default_nettype none

module dual_issue_core import core_pkg::*; (
    input  wire           clk,
    input  wire           rstn,
    input  wire           in_req,
    output logic          in_ack,
    input  wire instr_t   in_instr0,
    input  wire instr_t   in_instr1,
    input  wire           in_has1,
    output logic          res_req,
    input  wire           res_ack,
    output reg_idx_t      res_addr,
    output word_t         res_data,
    input  wire reg_idx_t dbg_num,
    output word_t         dbg_data
);

    reg_idx_t ra0j;
    reg_idx_t ra0k;
    reg_idx_t ra1j;
    reg_idx_t ra1k;
    word_t    rd0j;
    word_t    rd0k;
    word_t    rd1j;
    word_t    rd1k;
    wb_t      wb0;
    wb_t      wb1;
    logic     handoff;
    logic     out_empty;

    issue_if iss ();

    instr_intake u_intake (
        .clk(clk), .rstn(rstn),
        .in_req(in_req), .in_ack(in_ack),
        .in_instr0(in_instr0), .in_instr1(in_instr1), .in_has1(in_has1),
        .issue(iss.intake)
    );

    exec_stage u_exec (
        .clk(clk), .rstn(rstn), .issue(iss.exec),
        .ra0j(ra0j), .ra0k(ra0k), .ra1j(ra1j), .ra1k(ra1k),
        .rd0j(rd0j), .rd0k(rd0k), .rd1j(rd1j), .rd1k(rd1k),
        .wb0(wb0), .wb1(wb1), .handoff(handoff), .out_empty(out_empty)
    );

    // write ports follow the writeback pair on the handoff cycle.
    register_file u_rf (
        .clk(clk), .rstn(rstn),
        .we0(wb0.valid), .we1(wb1.valid),
        .wa0(wb0.addr), .wa1(wb1.addr),
        .wd0(wb0.data), .wd1(wb1.data),
        .ra0j(ra0j), .ra0k(ra0k), .ra1j(ra1j), .ra1k(ra1k),
        .rd0j(rd0j), .rd0k(rd0k), .rd1j(rd1j), .rd1k(rd1k),
        .dbg_num(dbg_num), .dbg_data(dbg_data)
    );

    result_port u_result (
        .clk(clk), .rstn(rstn),
        .wb0(wb0), .wb1(wb1), .handoff(handoff), .empty(out_empty),
        .res_req(res_req), .res_ack(res_ack),
        .res_addr(res_addr), .res_data(res_data)
    );

endmodule

`default_nettype wire

// File: tb/dual_issue_core_chk.sv
`timescale 1ns/1ps
`default_nettype none

module dual_issue_core_chk import core_pkg::*; (
    input wire           clk,
    input wire           rstn,
    input wire wb_t      wb0,
    input wire wb_t      wb1,
    input wire           res_req,
    input wire           res_ack,
    input wire reg_idx_t res_addr,
    input wire word_t    res_data
);

    // the split rule keeps both write ports off the same register.
    a_write_addr_differ: assert property (@(posedge clk) disable iff (!rstn)
        wb0.valid && wb1.valid |-> wb0.addr != wb1.addr)
        else $error("two register file writes to r%0d in one cycle", wb0.addr);

    a_no_r0_write0: assert property (@(posedge clk) disable iff (!rstn)
        wb0.valid |-> wb0.addr != 5'd0)
        else $error("write port 0 targets r0");

    a_no_r0_write1: assert property (@(posedge clk) disable iff (!rstn)
        wb1.valid |-> wb1.addr != 5'd0)
        else $error("write port 1 targets r0");

    a_res_stable: assert property (@(posedge clk) disable iff (!rstn)
        res_req |=> !res_req || ($stable(res_addr) && $stable(res_data)))
        else $error("result record changed while res_req was high");

    a_req_waits_ack: assert property (@(posedge clk) disable iff (!rstn)
        !res_req && res_ack |=> !res_req)
        else $error("res_req rose while res_ack was still high");

endmodule

// write ports and the result port are both visible at the top level.
bind dual_issue_core dual_issue_core_chk chk0 (
    .clk(clk), .rstn(rstn),
    .wb0(wb0), .wb1(wb1),
    .res_req(res_req), .res_ack(res_ack),
    .res_addr(res_addr), .res_data(res_data)
);

`default_nettype wire

// File: tb/dual_issue_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dual_issue_core_tb import core_pkg::*; ();

    localparam int          clk_period     = 4;
    localparam int          timeout_cycles = 500;
    localparam int          random_pairs   = 12;
    localparam logic [15:0] lfsr_seed      = 16'd77;

    logic     clk;
    logic     rstn;
    logic     in_req;
    logic     in_ack;
    instr_t   in_instr0;
    instr_t   in_instr1;
    logic     in_has1;
    logic     res_req;
    logic     res_ack;
    reg_idx_t res_addr;
    word_t    res_data;
    reg_idx_t dbg_num;
    word_t    dbg_data;

    // reference register state, in program order.
    word_t       model [nregs];
    reg_idx_t    exp_addr [$];
    word_t       exp_data [$];
    int          exp_cnt;
    int          got_cnt;
    int          errors;
    int          timeouts;
    logic [15:0] lfsr_q;
    string       test_name;
    logic        run_done;

    dual_issue_core dut0 (
        .clk(clk), .rstn(rstn),
        .in_req(in_req), .in_ack(in_ack),
        .in_instr0(in_instr0), .in_instr1(in_instr1), .in_has1(in_has1),
        .res_req(res_req), .res_ack(res_ack),
        .res_addr(res_addr), .res_data(res_data),
        .dbg_num(dbg_num), .dbg_data(dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected r%0d, actual r%0d", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // 16-bit fibonacci lfsr, taps 16 14 13 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    function automatic instr_t make_instr(input logic [3:0] op, input reg_idx_t rd,
                                          input reg_idx_t rj, input reg_idx_t rk,
                                          input logic [11:0] imm);
        instr_t w;
        w.op    = op;
        w.rd    = rd;
        w.rj    = rj;
        w.rk    = rk;
        w.imm12 = imm;
        w.spare = 1'b0;
        return w;
    endfunction

    task automatic random_instr(output instr_t w);
        logic [31:0] op;
        logic [31:0] rd;
        logic [31:0] rj;
        logic [31:0] rk;
        logic [31:0] imm;
        draw_bits(4, op);
        draw_bits(3, rd);
        draw_bits(3, rj);
        draw_bits(3, rk);
        draw_bits(12, imm);
        w = make_instr(op[3:0], {2'b00, rd[2:0]}, {2'b00, rj[2:0]}, {2'b00, rk[2:0]},
                       imm[11:0]);
    endtask

    // codes above addi do nothing, and r0 never changes.
    task automatic apply_instr(input instr_t w);
        word_t a;
        word_t b;
        word_t imm;
        word_t y;
        logic  live;
        a    = model[w.rj];
        b    = model[w.rk];
        imm  = {{20{w.imm12[11]}}, w.imm12};
        live = 1'b1;
        case (w.op)
            op_add:  y = a + b;
            op_sub:  y = a - b;
            op_and:  y = a & b;
            op_or:   y = a | b;
            op_xor:  y = a ^ b;
            op_sll:  y = a << b[4:0];
            op_srl:  y = a >> b[4:0];
            op_sltu: y = (a < b) ? 32'd1 : 32'd0;
            op_addi: y = a + imm;
            default: begin
                y    = '0;
                live = 1'b0;
            end
        endcase
        if (live && w.rd != 5'd0) begin
            model[w.rd] = y;
            exp_addr.push_back(w.rd);
            exp_data.push_back(y);
            exp_cnt++;
        end
    endtask

    task automatic wait_in_ack(input logic level);
        int n;
        n = 0;
        while (in_ack !== level && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (in_ack !== level) begin
            timeouts++;
            $display("timeout: in_ack never reached %b in test %s", level, test_name);
        end
    endtask

    task automatic send_pair(input instr_t i0, input instr_t i1, input logic has1);
        apply_instr(i0);
        if (has1) begin
            apply_instr(i1);
        end
        @(negedge clk);
        in_instr0 = i0;
        in_instr1 = i1;
        in_has1   = has1;
        in_req    = 1'b1;
        wait_in_ack(1'b1);
        in_req = 1'b0;
        wait_in_ack(1'b0);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_addr.size() != 0 || res_req || res_ack) && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (exp_addr.size() != 0 || res_req || res_ack) begin
            timeouts++;
            $display("timeout: %0d result records never arrived in test %s",
                     exp_addr.size(), test_name);
        end
        check_count({test_name, " record count"}, exp_cnt, got_cnt);
    endtask

    task automatic check_regs();
        for (int i = 0; i < nregs; i++) begin
            @(negedge clk);
            dbg_num = reg_idx_t'(i);
            @(posedge clk);
            check_word($sformatf("%s dbg r%0d", test_name, i), model[i], dbg_data);
        end
    endtask

    task automatic take_record();
        reg_idx_t a;
        word_t    d;
        if (exp_addr.size() == 0) begin
            errors++;
            $display("unexpected result record for r%0d in test %s", res_addr, test_name);
        end else begin
            a = exp_addr.pop_front();
            d = exp_data.pop_front();
            check_addr({test_name, " record addr"}, a, res_addr);
            check_word({test_name, " record data"}, d, res_data);
        end
        got_cnt++;
    endtask

    // acknowledges each record after 0 to 7 cycles.
    initial begin : responder
        logic [31:0] delay;
        int          n;
        forever begin
            @(negedge clk);
            if (rstn && res_req && !res_ack) begin
                take_record();
                draw_bits(3, delay);
                repeat (delay) @(negedge clk);
                res_ack = 1'b1;
                n = 0;
                while (res_req && n < timeout_cycles) begin
                    @(negedge clk);
                    n++;
                end
                if (res_req) begin
                    timeouts++;
                    $display("timeout: res_req stayed high after res_ack in test %s", test_name);
                end
                res_ack = 1'b0;
            end
        end
    end

    task automatic start_test(input string name);
        test_name = name;
        exp_cnt   = 0;
        got_cnt   = 0;
        $display("running %s", name);
    endtask

    task automatic reset_state();
        start_test("reset_state");
        check_bit("reset_state in_ack", 1'b0, in_ack);
        check_bit("reset_state res_req", 1'b0, res_req);
        check_regs();
    endtask

    task automatic independent_pairs();
        start_test("independent_pairs");
        send_pair(make_instr(op_addi, 5'd1, 5'd0, 5'd0, 12'd100),
                  make_instr(op_addi, 5'd2, 5'd0, 5'd0, 12'hffb), 1'b1);
        send_pair(make_instr(op_addi, 5'd3, 5'd0, 5'd0, 12'h7ff),
                  make_instr(op_add, 5'd4, 5'd1, 5'd2, 12'd0), 1'b1);
        send_pair(make_instr(op_sub, 5'd5, 5'd1, 5'd2, 12'd0),
                  make_instr(op_xor, 5'd6, 5'd3, 5'd1, 12'd0), 1'b1);
        send_pair(make_instr(op_sll, 5'd7, 5'd1, 5'd2, 12'd0),
                  make_instr(op_srl, 5'd8, 5'd3, 5'd1, 12'd0), 1'b1);
        send_pair(make_instr(op_sltu, 5'd9, 5'd2, 5'd1, 12'd0),
                  make_instr(op_or, 5'd10, 5'd1, 5'd3, 12'd0), 1'b1);
        send_pair(make_instr(op_and, 5'd11, 5'd2, 5'd3, 12'd0),
                  make_instr(op_addi, 5'd20, 5'd0, 5'd0, 12'd9), 1'b0);
        wait_drain();
        check_regs();
    endtask

    task automatic raw_dependence();
        start_test("raw_dependence");
        send_pair(make_instr(op_addi, 5'd12, 5'd1, 5'd0, 12'd7),
                  make_instr(op_add, 5'd13, 5'd12, 5'd12, 12'd0), 1'b1);
        send_pair(make_instr(op_addi, 5'd14, 5'd0, 5'd0, 12'd3),
                  make_instr(op_sll, 5'd15, 5'd1, 5'd14, 12'd0), 1'b1);
        send_pair(make_instr(op_addi, 5'd21, 5'd0, 5'd0, 12'hfff),
                  make_instr(op_addi, 5'd22, 5'd21, 5'd0, 12'd2), 1'b1);
        wait_drain();
        check_regs();
    endtask

    task automatic same_dest_pair();
        start_test("same_dest_pair");
        send_pair(make_instr(op_addi, 5'd16, 5'd0, 5'd0, 12'd11),
                  make_instr(op_addi, 5'd16, 5'd0, 5'd0, 12'd22), 1'b1);
        send_pair(make_instr(op_add, 5'd17, 5'd1, 5'd2, 12'd0),
                  make_instr(op_sub, 5'd17, 5'd17, 5'd1, 12'd0), 1'b1);
        wait_drain();
        check_regs();
    endtask

    task automatic silent_instrs();
        start_test("silent_instrs");
        send_pair(make_instr(op_addi, 5'd0, 5'd1, 5'd0, 12'd5),
                  make_instr(4'd15, 5'd18, 5'd1, 5'd2, 12'd0), 1'b1);
        send_pair(make_instr(4'd12, 5'd19, 5'd1, 5'd2, 12'd0),
                  make_instr(op_add, 5'd0, 5'd1, 5'd2, 12'd0), 1'b1);
        // one real write behind the silent pairs retires only after both of them.
        send_pair(make_instr(op_addi, 5'd23, 5'd0, 5'd0, 12'd1),
                  make_instr(4'd15, 5'd0, 5'd0, 5'd0, 12'd0), 1'b1);
        wait_drain();
        check_regs();
    endtask

    // all stimulus is drawn first so the responder owns the lfsr while pairs run.
    task automatic random_backpressure();
        instr_t      slot0 [random_pairs];
        instr_t      slot1 [random_pairs];
        logic        has1 [random_pairs];
        logic [31:0] v;
        start_test("random_backpressure");
        for (int i = 0; i < random_pairs; i++) begin
            random_instr(slot0[i]);
            random_instr(slot1[i]);
            draw_bits(2, v);
            has1[i] = (v[1:0] != 2'b00);
        end
        for (int i = 0; i < random_pairs; i++) begin
            send_pair(slot0[i], slot1[i], has1[i]);
        end
        wait_drain();
        check_regs();
    endtask

    initial begin
        rstn      = 1'b0;
        in_req    = 1'b0;
        in_instr0 = '0;
        in_instr1 = '0;
        in_has1   = 1'b0;
        res_ack   = 1'b0;
        dbg_num   = '0;
        errors    = 0;
        timeouts  = 0;
        exp_cnt   = 0;
        got_cnt   = 0;
        run_done  = 1'b0;
        lfsr_q    = lfsr_seed;
        test_name = "init";
        for (int i = 0; i < nregs; i++) begin
            model[i] = '0;
        end
        repeat (4) @(negedge clk);
        rstn = 1'b1;
        reset_state();
        independent_pairs();
        raw_dependence();
        same_dest_pair();
        silent_instrs();
        random_backpressure();
        $display("errors: %0d check, %0d timeout", errors, timeouts);
        run_done = 1'b1;
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    final begin
        if (!run_done) begin
            $display("Test failures found");
        end
    end

endmodule

`default_nettype wire

// File: dual_issue_core.f
hdl/core_pkg.sv
hdl/issue_if.sv
hdl/alu.sv
hdl/register_file.sv
hdl/instr_intake.sv
hdl/exec_stage.sv
hdl/result_port.sv
hdl/dual_issue_core.sv
tb/dual_issue_core_chk.sv
tb/dual_issue_core_tb.sv

// File: Makefile
TOOL      ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= dual_issue_core_tb
FILELIST  ?= dual_issue_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Test failures found
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP), fail if $(LOG) reports failures"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
